// ==== dcache_data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_data_ram (
    input  logic                    clk,
    input  logic                    en,
    input  dcache_pkg::data_addr_t  addr,
    input  dcache_pkg::strobe_t     strobe,
    input  dcache_pkg::word_t       wdata,
    output dcache_pkg::word_t       rdata
);
    import dcache_pkg::*;

    localparam int depth = n_ways * n_sets * line_words;

    word_t mem [depth];
    word_t mask;

    assign mask = strobe_mask(strobe);

    // read returns the contents from before the write
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
            if (|strobe) begin
                mem[addr] <= (mem[addr] & ~mask) | (wdata & mask);
            end
        end
    end

endmodule

`default_nettype wire

// ==== dcache_miss_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_miss_ctrl (
    input  logic                    clk,
    input  logic                    resetn,
    input  dcache_pkg::core_req_t   req,
    input  logic                    hit,
    input  dcache_pkg::way_t        victim_way,
    input  logic                    victim_valid,
    input  logic                    victim_dirty,
    input  dcache_pkg::tag_t        victim_tag,
    output logic                    idle,
    output logic                    ram_en,
    output dcache_pkg::data_addr_t  ram_addr,
    output dcache_pkg::strobe_t     ram_strobe,
    output dcache_pkg::word_t       ram_wdata,
    input  dcache_pkg::word_t       ram_rdata,
    output logic                    fill,
    output dcache_pkg::cbus_req_t   creq,
    input  dcache_pkg::cbus_resp_t  cresp
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_victim_read,
        s_write_back,
        s_refill
    } state_t;

    state_t state;

    // counts ram reads during victim read, bus beats otherwise
    logic [offset_bits:0] cnt;
    offset_t cnt_off;

    tag_t miss_tag;
    index_t miss_index;
    way_t miss_way;
    tag_t old_tag;

    word_t line_buf [line_words];

    logic miss;
    logic beat_done;

    assign cnt_off = cnt[offset_bits-1:0];
    assign miss = req.valid && !hit;
    assign beat_done = cresp.ready;
    assign idle = (state == s_idle);
    assign fill = (state == s_refill) && cresp.ready && cresp.last;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= s_idle;
            cnt <= '0;
        end else begin
            case (state)
                s_idle: begin
                    cnt <= '0;
                    if (miss) begin
                        if (victim_valid && victim_dirty) begin
                            state <= s_victim_read;
                        end else begin
                            state <= s_refill;
                        end
                    end
                end
                s_victim_read: begin
                    // one extra cycle for the last read to come back
                    if (cnt == line_words) begin
                        state <= s_write_back;
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                s_write_back: begin
                    if (beat_done) begin
                        cnt <= cnt + 1'b1;
                        if (cresp.last) begin
                            state <= s_refill;
                            cnt <= '0;
                        end
                    end
                end
                s_refill: begin
                    if (beat_done) begin
                        cnt <= cnt + 1'b1;
                        if (cresp.last) begin
                            state <= s_idle;
                            cnt <= '0;
                        end
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // miss context taken when leaving idle
    always_ff @(posedge clk) begin
        if (idle && miss) begin
            miss_tag <= req.addr.tag;
            miss_index <= req.addr.index;
            miss_way <= victim_way;
            old_tag <= victim_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_victim_read && cnt != 0) begin
            line_buf[offset_t'(cnt - 1'b1)] <= ram_rdata;
        end
    end

    // data ram side
    always_comb begin
        ram_en = 1'b0;
        ram_strobe = '0;
        ram_addr.way = miss_way;
        ram_addr.index = miss_index;
        ram_addr.offset = cnt_off;
        case (state)
            s_victim_read: begin
                ram_en = (cnt < line_words);
            end
            s_refill: begin
                ram_en = beat_done;
                ram_strobe = '1;
            end
            default: begin
            end
        endcase
    end

    assign ram_wdata = cresp.data;

    // cache bus side
    always_comb begin
        creq.valid = (state == s_write_back) || (state == s_refill);
        creq.is_write = (state == s_write_back);
        creq.addr.tag = (state == s_write_back) ? old_tag : miss_tag;
        creq.addr.index = miss_index;
        creq.addr.offset = '0;
        creq.addr.align = '0;
        creq.data = line_buf[cnt_off];
    end

    assert property (@(posedge clk) disable iff (resetn)
        creq.valid && !cresp.ready |=> $stable(creq))
        else $error("dcache_miss_ctrl: bus request changed while stalled");

endmodule

`default_nettype wire

// ==== dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int n_ways = 4;
    localparam int n_sets = 16;
    localparam int line_words = 4;
    localparam int word_bytes = 4;
    localparam int word_bits = 32;
    localparam int addr_bits = 32;

    localparam int way_bits = $clog2(n_ways);
    localparam int index_bits = $clog2(n_sets);
    localparam int offset_bits = $clog2(line_words);
    localparam int align_bits = $clog2(word_bytes);
    localparam int tag_bits = addr_bits - index_bits - offset_bits - align_bits;

    typedef logic [word_bits-1:0] word_t;
    typedef logic [word_bytes-1:0] strobe_t;
    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [index_bits-1:0] index_t;
    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [align_bits-1:0] align_t;
    typedef logic [way_bits-1:0] way_t;

    // one bit per inner node of the tree
    typedef logic [n_ways-2:0] plru_t;

    typedef struct packed {
        tag_t tag;
        index_t index;
        offset_t offset;
        align_t align;
    } addr_t;

    typedef struct packed {
        way_t way;
        index_t index;
        offset_t offset;
    } data_addr_t;

    // zero strobe means read
    typedef struct packed {
        logic valid;
        addr_t addr;
        strobe_t strobe;
        word_t data;
    } core_req_t;

    typedef struct packed {
        logic addr_ok;
        logic data_ok;
        word_t data;
    } core_resp_t;

    // addr is the line-aligned start of the burst
    typedef struct packed {
        logic valid;
        logic is_write;
        addr_t addr;
        word_t data;
    } cbus_req_t;

    typedef struct packed {
        logic ready;
        logic last;
        word_t data;
    } cbus_resp_t;

    function automatic word_t strobe_mask(input strobe_t strobe);
        word_t mask;
        for (int i = 0; i < word_bytes; i++) begin
            mask[i*8 +: 8] = {8{strobe[i]}};
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

// ==== dcache_tag_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_store (
    input  logic                clk,
    input  logic                resetn,
    input  dcache_pkg::index_t  index,
    input  dcache_pkg::tag_t    tag,
    output logic                hit,
    output dcache_pkg::way_t    hit_way,
    input  dcache_pkg::way_t    victim_way,
    output logic                victim_valid,
    output logic                victim_dirty,
    output dcache_pkg::tag_t    victim_tag,
    input  logic                mark_dirty,
    input  logic                fill
);
    import dcache_pkg::*;

    logic [n_sets-1:0][n_ways-1:0] valid_q;
    logic [n_sets-1:0][n_ways-1:0] dirty_q;
    tag_t tag_q [n_sets][n_ways];

    logic [n_ways-1:0] hit_bits;

    // parallel compare over all ways of the set
    always_comb begin
        for (int w = 0; w < n_ways; w++) begin
            hit_bits[w] = valid_q[index][w] && (tag_q[index][w] == tag);
        end
    end

    assign hit = |hit_bits;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < n_ways; w++) begin
            if (hit_bits[w]) begin
                hit_way |= way_t'(w);
            end
        end
    end

    assign victim_valid = valid_q[index][victim_way];
    assign victim_dirty = dirty_q[index][victim_way];
    assign victim_tag = tag_q[index][victim_way];

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (mark_dirty) begin
                dirty_q[index][hit_way] <= 1'b1;
            end
            // new line comes in clean
            if (fill) begin
                valid_q[index][victim_way] <= 1'b1;
                dirty_q[index][victim_way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[index][victim_way] <= tag;
        end
    end

    // fill only installs a tag that missed, so a tag never lives in two ways
    assert property (@(posedge clk) disable iff (resetn) $onehot0(hit_bits))
        else $error("dcache_tag_store: more than one way hits");

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  logic                    clk,
    input  logic                    resetn,
    input  dcache_pkg::core_req_t   req,
    output dcache_pkg::core_resp_t  resp,
    output dcache_pkg::cbus_req_t   creq,
    input  dcache_pkg::cbus_resp_t  cresp
);
    import dcache_pkg::*;

    logic hit;
    way_t hit_way;
    way_t victim_way;
    logic victim_valid;
    logic victim_dirty;
    tag_t victim_tag;
    logic idle;
    logic fill;
    logic accept;
    logic data_ok_q;

    logic ctrl_en;
    data_addr_t ctrl_addr;
    strobe_t ctrl_strobe;
    word_t ctrl_wdata;

    logic ram_en;
    data_addr_t ram_addr;
    strobe_t ram_strobe;
    word_t ram_wdata;
    word_t ram_rdata;

    // hit in idle is accepted in the same cycle
    assign accept = req.valid && hit && idle;

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= accept;
        end
    end

    assign resp.addr_ok = accept;
    assign resp.data_ok = data_ok_q;
    assign resp.data = ram_rdata;

    // controller owns the ram outside idle
    always_comb begin
        if (idle) begin
            ram_en = accept;
            ram_addr.way = hit_way;
            ram_addr.index = req.addr.index;
            ram_addr.offset = req.addr.offset;
            ram_strobe = req.strobe;
            ram_wdata = req.data;
        end else begin
            ram_en = ctrl_en;
            ram_addr = ctrl_addr;
            ram_strobe = ctrl_strobe;
            ram_wdata = ctrl_wdata;
        end
    end

    dcache_tag_store i_tag_store (
        .clk          (clk),
        .resetn       (resetn),
        .index        (req.addr.index),
        .tag          (req.addr.tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .mark_dirty   (accept && |req.strobe),
        .fill         (fill)
    );

    plru_tree i_plru_tree (
        .clk        (clk),
        .resetn     (resetn),
        .index      (req.addr.index),
        .touch      (accept || fill),
        .touch_way  (fill ? victim_way : hit_way),
        .victim_way (victim_way)
    );

    dcache_data_ram i_data_ram (
        .clk    (clk),
        .en     (ram_en),
        .addr   (ram_addr),
        .strobe (ram_strobe),
        .wdata  (ram_wdata),
        .rdata  (ram_rdata)
    );

    dcache_miss_ctrl i_miss_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .req          (req),
        .hit          (hit),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .idle         (idle),
        .ram_en       (ctrl_en),
        .ram_addr     (ctrl_addr),
        .ram_strobe   (ctrl_strobe),
        .ram_wdata    (ctrl_wdata),
        .ram_rdata    (ram_rdata),
        .fill         (fill),
        .creq         (creq),
        .cresp        (cresp)
    );

endmodule

`default_nettype wire

// ==== filelist.f ====
dcache_pkg.sv
dcache_tag_store.sv
plru_tree.sv
dcache_data_ram.sv
dcache_miss_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

// ==== plru_tree.sv ====
`timescale 1ns/1ns
`default_nettype none

module plru_tree (
    input  logic                clk,
    input  logic                resetn,
    input  dcache_pkg::index_t  index,
    input  logic                touch,
    input  dcache_pkg::way_t    touch_way,
    output dcache_pkg::way_t    victim_way
);
    import dcache_pkg::*;

    plru_t bits_q [n_sets];
    plru_t cur;
    plru_t nxt;

    assign cur = bits_q[index];

    // walk from the root, zero goes left
    always_comb begin
        int node;
        node = 0;
        victim_way = '0;
        for (int lvl = 0; lvl < way_bits; lvl++) begin
            victim_way[way_bits-1-lvl] = cur[node];
            node = 2 * node + 1 + int'(cur[node]);
        end
    end

    // point every node on the path away from the touched way
    always_comb begin
        int node;
        logic dir;
        node = 0;
        nxt = cur;
        for (int lvl = 0; lvl < way_bits; lvl++) begin
            dir = touch_way[way_bits-1-lvl];
            nxt[node] = ~dir;
            node = 2 * node + 1 + int'(dir);
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < n_sets; s++) begin
                bits_q[s] <= '0;
            end
        end else if (touch) begin
            bits_q[index] <= nxt;
        end
    end

endmodule

`default_nettype wire

// ==== tb_dcache.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int clk_period = 100;
    localparam int reset_cycles = 10;
    localparam int max_rows = 32;
    localparam int mem_words = 4096;
    localparam int row_cycles = 2 * line_words * 16 + 40;
    localparam word_t init_xor = 32'h5a5a_0000;

    typedef struct packed {
        logic is_write;
        addr_t addr;
        strobe_t strobe;
        word_t data;
        word_t exp_word;
        logic exp_miss;
        logic exp_wb;
        addr_t wb_addr;
    } row_t;

    logic clk;
    logic resetn;
    core_req_t req;
    core_resp_t resp;
    cbus_req_t creq;
    cbus_resp_t cresp;
    int rd_bursts;
    int wr_bursts;
    addr_t wb_addr;

    row_t rows [max_rows];
    word_t wb_words [max_rows][line_words];
    int n_rows;
    int errors;
    int rows_ok;
    int rows_bad;
    logic checks_on;

    // reference model of memory as the core sees it, and of the tags
    word_t shadow [mem_words];
    logic ref_valid [n_sets][n_ways];
    logic ref_dirty [n_sets][n_ways];
    tag_t ref_tag [n_sets][n_ways];
    plru_t ref_plru [n_sets];

    dcache_top i_dcache_top (
        .clk    (clk),
        .resetn (resetn),
        .req    (req),
        .resp   (resp),
        .creq   (creq),
        .cresp  (cresp)
    );

    tb_mem_model i_mem (
        .clk       (clk),
        .resetn    (resetn),
        .creq      (creq),
        .cresp     (cresp),
        .rd_bursts (rd_bursts),
        .wr_bursts (wr_bursts),
        .wb_addr   (wb_addr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic int word_index(input addr_t a);
        logic [addr_bits-1:0] flat;
        flat = a;
        return int'(flat[13:2]);
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data, input strobe_t s);
        word_t res;
        res = old;
        for (int b = 0; b < word_bytes; b++) begin
            if (s[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // bit 0 is the root with bits 1 and 2 for the lower and upper pair
    function automatic way_t plru_victim(input plru_t b);
        way_t v;
        v[1] = b[0];
        v[0] = b[0] ? b[2] : b[1];
        return v;
    endfunction

    function automatic plru_t plru_touch(input plru_t b, input way_t w);
        plru_t n;
        n = b;
        n[0] = ~w[1];
        if (w[1]) begin
            n[2] = ~w[0];
        end else begin
            n[1] = ~w[0];
        end
        return n;
    endfunction

    task automatic add_row(input logic is_write, input tag_t tag, input index_t index,
                           input offset_t offset, input strobe_t strobe, input word_t data);
        row_t row;
        row = '0;
        row.is_write = is_write;
        row.addr.tag = tag;
        row.addr.index = index;
        row.addr.offset = offset;
        row.strobe = strobe;
        row.data = data;
        rows[n_rows] = row;
        n_rows++;
    endtask

    task automatic build_table();
        // one line in set 2 with byte merges
        add_row(1'b0, 1, 2, 1, 4'h0, 32'h0);
        add_row(1'b0, 1, 2, 3, 4'h0, 32'h0);
        add_row(1'b1, 1, 2, 1, 4'b0101, 32'hdead_beef);
        add_row(1'b0, 1, 2, 1, 4'h0, 32'h0);
        add_row(1'b1, 1, 2, 2, 4'b1000, 32'h1234_5678);
        add_row(1'b0, 1, 2, 2, 4'h0, 32'h0);
        // five dirty lines into set 5
        add_row(1'b1, 10, 5, 0, 4'hf, 32'ha0a0_0010);
        add_row(1'b1, 11, 5, 1, 4'hf, 32'ha0a0_0011);
        add_row(1'b1, 12, 5, 2, 4'b0011, 32'ha0a0_0012);
        add_row(1'b1, 13, 5, 3, 4'b1100, 32'ha0a0_0013);
        add_row(1'b1, 14, 5, 0, 4'hf, 32'ha0a0_0014);
        add_row(1'b0, 10, 5, 0, 4'h0, 32'h0);
        // hits that steer the tree before a miss
        add_row(1'b0, 12, 5, 2, 4'h0, 32'h0);
        add_row(1'b0, 14, 5, 0, 4'h0, 32'h0);
        add_row(1'b0, 13, 5, 3, 4'h0, 32'h0);
        add_row(1'b0, 15, 5, 1, 4'h0, 32'h0);
        add_row(1'b0, 12, 5, 2, 4'h0, 32'h0);
        add_row(1'b0, 11, 5, 1, 4'h0, 32'h0);
        add_row(1'b0, 1, 2, 0, 4'h0, 32'h0);
        add_row(1'b0, 1, 2, 1, 4'h0, 32'h0);
    endtask

    task automatic init_reference();
        for (int i = 0; i < mem_words; i++) begin
            shadow[i] = word_t'(i * word_bytes) ^ init_xor;
        end
        for (int s = 0; s < n_sets; s++) begin
            ref_plru[s] = '0;
            for (int w = 0; w < n_ways; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_tag[s][w] = '0;
            end
        end
    endtask

    // fills the expected columns of every row
    task automatic predict_rows();
        row_t row;
        addr_t line;
        int s;
        int hw;
        int idx;
        logic found;
        for (int r = 0; r < n_rows; r++) begin
            row = rows[r];
            s = int'(row.addr.index);
            found = 1'b0;
            hw = 0;
            for (int w = 0; w < n_ways; w++) begin
                if (ref_valid[s][w] && ref_tag[s][w] == row.addr.tag) begin
                    found = 1'b1;
                    hw = w;
                end
            end
            row.exp_miss = !found;
            if (!found) begin
                hw = int'(plru_victim(ref_plru[s]));
                if (ref_valid[s][hw] && ref_dirty[s][hw]) begin
                    line = '0;
                    line.tag = ref_tag[s][hw];
                    line.index = row.addr.index;
                    row.exp_wb = 1'b1;
                    row.wb_addr = line;
                    for (int o = 0; o < line_words; o++) begin
                        line.offset = offset_t'(o);
                        wb_words[r][o] = shadow[word_index(line)];
                    end
                end
                ref_valid[s][hw] = 1'b1;
                ref_dirty[s][hw] = 1'b0;
                ref_tag[s][hw] = row.addr.tag;
            end
            // fill and the retried hit touch the same way
            ref_plru[s] = plru_touch(ref_plru[s], way_t'(hw));
            idx = word_index(row.addr);
            row.exp_word = shadow[idx];
            if (row.is_write) begin
                ref_dirty[s][hw] = 1'b1;
                shadow[idx] = merge_bytes(shadow[idx], row.data, row.strobe);
            end
            rows[r] = row;
        end
    endtask

    // called on a falling edge and returns on the falling edge after data_ok
    task automatic run_row(input int r);
        row_t row;
        addr_t line;
        int rd_before;
        int wr_before;
        int err_before;
        row = rows[r];
        err_before = errors;
        rd_before = rd_bursts;
        wr_before = wr_bursts;
        req.valid = 1'b1;
        req.addr = row.addr;
        req.strobe = row.is_write ? row.strobe : '0;
        req.data = row.data;
        #1;
        while (!resp.addr_ok) begin
            @(negedge clk);
            #1;
        end
        check_flag("refill before addr_ok", rd_bursts != rd_before, row.exp_miss);
        check_flag("write burst before addr_ok", wr_bursts != wr_before, row.exp_wb);
        if (row.exp_wb) begin
            check_addr("write-back address", wb_addr, row.wb_addr);
            line = row.wb_addr;
            for (int o = 0; o < line_words; o++) begin
                line.offset = offset_t'(o);
                check_word("memory copy of victim", i_mem.read_word(line), wb_words[r][o]);
            end
        end
        @(negedge clk);
        check_flag("data_ok", resp.data_ok, 1'b1);
        if (!row.is_write) begin
            check_word("read data", resp.data, row.exp_word);
        end
        if (errors == err_before) begin
            rows_ok++;
        end else begin
            rows_bad++;
        end
        $display("row %0d: %s %h, %s%s: %s", r, row.is_write ? "write" : "read",
                 row.addr, row.exp_miss ? "miss" : "hit",
                 row.exp_wb ? " with write-back" : "",
                 (errors == err_before) ? "ok" : "failed");
    endtask

    // data_ok one cycle after addr_ok and no accept while the bus is busy
    initial begin
        logic prev_addr_ok;
        prev_addr_ok = 1'b0;
        wait (checks_on);
        forever begin
            @(negedge clk);
            #1;
            check_flag("data_ok one cycle after addr_ok", resp.data_ok, prev_addr_ok);
            if (creq.valid) begin
                check_flag("addr_ok during a burst", resp.addr_ok, 1'b0);
            end
            prev_addr_ok = resp.addr_ok;
        end
    end

    initial begin
        wait (checks_on);
        repeat (n_rows * row_cycles) @(posedge clk);
        $display("timeout: the cache did not finish the table in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        req = '0;
        resetn = 1'b1;
        checks_on = 1'b0;
        errors = 0;
        rows_ok = 0;
        rows_bad = 0;
        n_rows = 0;
        init_reference();
        build_table();
        predict_rows();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        resetn = 1'b0;
        #1;
        check_flag("creq.valid after reset", creq.valid, 1'b0);
        check_flag("data_ok after reset", resp.data_ok, 1'b0);
        checks_on = 1'b1;
        @(negedge clk);
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        req = '0;
        repeat (4) @(negedge clk);
        $display("rows passed: %0d, rows failed: %0d, errors: %0d", rows_ok, rows_bad, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model (
    input  logic                    clk,
    input  logic                    resetn,
    input  dcache_pkg::cbus_req_t   creq,
    output dcache_pkg::cbus_resp_t  cresp,
    output int                      rd_bursts,
    output int                      wr_bursts,
    output dcache_pkg::addr_t       wb_addr
);
    import dcache_pkg::*;

    localparam int mem_words = 4096;

    word_t mem [mem_words];
    offset_t beat;

    function automatic int word_index(input addr_t a);
        logic [addr_bits-1:0] flat;
        flat = a;
        return int'(flat[13:2]);
    endfunction

    function automatic word_t read_word(input addr_t a);
        return mem[word_index(a)];
    endfunction

    initial begin
        addr_t a;
        void'($urandom(32'hb61d_890a));
        cresp = '0;
        beat = '0;
        rd_bursts = 0;
        wr_bursts = 0;
        wb_addr = '0;
        // every word starts as its own byte address with a marker
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = word_t'(i * word_bytes) ^ 32'h5a5a_0000;
        end
        // the beat offered here completes at the next rising edge
        forever begin
            @(negedge clk);
            if (resetn) begin
                cresp <= '0;
                beat <= '0;
                rd_bursts <= 0;
                wr_bursts <= 0;
                wb_addr <= '0;
            end else begin
                a = creq.addr;
                a.offset = beat;
                cresp.ready <= 1'b0;
                cresp.last <= 1'b0;
                if (creq.valid && (($urandom % 4) != 0)) begin
                    cresp.ready <= 1'b1;
                    cresp.last <= (beat == offset_t'(line_words - 1));
                    if (creq.is_write) begin
                        mem[word_index(a)] = creq.data;
                    end else begin
                        cresp.data <= mem[word_index(a)];
                    end
                    beat <= beat + 1'b1;
                    if (beat == offset_t'(line_words - 1)) begin
                        if (creq.is_write) begin
                            wr_bursts <= wr_bursts + 1;
                            wb_addr <= creq.addr;
                        end else begin
                            rd_bursts <= rd_bursts + 1;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire
